// File: rv_exec_pkg.sv
// RV32I execute definitions
// Operation codes, unit selector and memory access sizes
package rv_exec_pkg;

    localparam int XLEN = 32;                   // Integer register width

    ////////////////////////////////////////
    // Operation within a unit
    ////////////////////////////////////////
    // ADD_U:    OP0 add, OP1 sub, OP2 sltu, OP3 slt
    // LOGIC_U:  OP0 xor, OP1 or, else and
    // SHIFT_U:  OP0 sll, OP1 srl, else sra
    // BRANCH_U: OP0..OP5 beq bne blt bltu bge bgeu, OP6 jal, OP7 jalr
    // MEM_U:    OP0..OP4 lb lbu lh lhu lw, OP5 sw, OP6 sh, OP7 sb
    typedef enum logic [2:0] {
        OP0,
        OP1,
        OP2,
        OP3,
        OP4,
        OP5,
        OP6,
        OP7
    } instruction_type;

    // Execution unit selector
    typedef enum logic [2:0] {
        ADD_U,                                  // Adder and compares
        LOGIC_U,                                // Bitwise ops
        SHIFT_U,                                // Barrel shifter
        BRANCH_U,                               // Branches and jumps
        MEM_U,                                  // Loads and stores
        BYPASS_U                                // LUI, NOP, invalid
    } exec_unit_e;

    // Data memory access width
    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } access_size_e;

endpackage

// File: exec_bus_pkg.sv
// Execute stage bus packets
// Issue and result packets, Wishbone request/response, queue sizing
package exec_bus_pkg;

    import rv_exec_pkg::*;

    localparam int QUEUE_DEPTH = 4;             // Issue queue entries
    localparam int TAG_W       = 4;             // Packet tag width
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);

    ////////////////////////////////////////
    // Issue and result packets
    ////////////////////////////////////////
    typedef struct packed {
        exec_unit_e        unit;                // Target unit
        instruction_type   op;                  // Op within unit
        logic [XLEN-1:0]   op_a;                // Source A or base address
        logic [XLEN-1:0]   op_b;                // Source B or immediate
        logic [XLEN-1:0]   data;                // Store data
        logic [XLEN-1:0]   npc;                 // Program counter
        logic [XLEN-1:0]   offset;              // Branch immediate
        logic [TAG_W-1:0]  tag;                 // Issue order tag
    } issue_pkt_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;                 // Copied from issue
        logic [XLEN-1:0]   value;               // Unit result, load data or target
        logic [XLEN-1:0]   link;                // npc+4
        logic              jump;                // Branch taken
        logic              reg_we;              // Register write back
        logic              mem_fault;           // Tied low, no faults yet
    } result_pkt_t;

    ////////////////////////////////////////
    // Wishbone classic
    ////////////////////////////////////////
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [XLEN-1:0]   adr;
        logic [XLEN-1:0]   dat_w;
        logic [XLEN/8-1:0] sel;                 // Byte lanes
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [XLEN-1:0]   dat_r;
    } wb_rsp_t;

endpackage

// File: issue_queue.sv
// Issue queue
// Circular buffer of issue packets, valid/ready in, head/pop out
`timescale 1ns/1ns

module issue_queue
    import exec_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  issue_pkt_t in_pkt,
    input  logic       in_valid,
    output logic       in_ready,
    output issue_pkt_t head_pkt,
    output logic       head_valid,
    input  logic       pop
);

    issue_pkt_t       slots [QUEUE_DEPTH];      // Packet storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                    // Occupancy
    logic             push;

    // Wrap at the last slot
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign push       = in_valid && in_ready;
    assign in_ready   = (count != (PTR_W + 1)'(QUEUE_DEPTH));  // Full stalls issue
    assign head_valid = (count != '0);
    assign head_pkt   = slots[rd_ptr];

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (push)
            slots[wr_ptr] <= in_pkt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

endmodule

// File: int_unit.sv
// Integer unit
// Adder, logic, shifter and bypass datapaths, picked by unit and op
`timescale 1ns/1ns

module int_unit
    import rv_exec_pkg::*;
(
    input  exec_unit_e      unit,
    input  instruction_type op,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic [XLEN-1:0] value
);

    logic [4:0] shamt;                          // Only low 5 bits shift

    assign shamt = op_b[4:0];

    always_comb begin
        case (unit)
            ////////////////////////////////////////
            // Adder
            ////////////////////////////////////////
            ADD_U: begin
                case (op)
                    OP1:     value = op_a - op_b;                   // SUB
                    OP2:     value = XLEN'(op_a < op_b);            // SLTU
                    OP3:     value = XLEN'($signed(op_a) < $signed(op_b)); // SLT
                    default: value = op_a + op_b;                   // ADD, ADDI, AUIPC
                endcase
            end
            LOGIC_U: begin
                case (op)
                    OP0:     value = op_a ^ op_b;   // XOR
                    OP1:     value = op_a | op_b;   // OR
                    default: value = op_a & op_b;   // AND
                endcase
            end
            ////////////////////////////////////////
            // Shifter
            ////////////////////////////////////////
            SHIFT_U: begin
                case (op)
                    OP0:     value = op_a << shamt;             // SLL
                    OP1:     value = op_a >> shamt;             // SRL
                    default: value = $signed(op_a) >>> shamt;   // SRA
                endcase
            end
            BYPASS_U: value = op_a;             // LUI and NOP
            default:  value = '0;               // Branch and memory elsewhere
        endcase
    end

endmodule

// File: branch_unit.sv
// Branch unit
// Condition, target and link for conditional branches, JAL and JALR
`timescale 1ns/1ns

module branch_unit
    import rv_exec_pkg::*;
(
    input  instruction_type op,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    input  logic [XLEN-1:0] npc,
    input  logic [XLEN-1:0] offset,
    output logic [XLEN-1:0] target,
    output logic [XLEN-1:0] link,
    output logic            jump,
    output logic            reg_we
);

    logic [XLEN-1:0] sum;                       // Jump target base

    assign sum    = op_a + op_b;
    assign link   = npc + XLEN'(4);             // Return address
    assign reg_we = (op == OP6) || (op == OP7); // Only jumps write rd

    // Target
    always_comb begin
        case (op)
            OP6:     target = sum;                      // JAL
            OP7:     target = {sum[XLEN-1:1], 1'b0};    // JALR, bit 0 cleared
            default: target = npc + offset;             // Conditional
        endcase
    end

    ////////////////////////////////////////
    // Branch condition
    ////////////////////////////////////////
    always_comb begin
        case (op)
            OP0:     jump = (op_a == op_b);                     // BEQ
            OP1:     jump = (op_a != op_b);                     // BNE
            OP2:     jump = ($signed(op_a) < $signed(op_b));    // BLT
            OP3:     jump = (op_a < op_b);                      // BLTU
            OP4:     jump = ($signed(op_a) >= $signed(op_b));   // BGE
            OP5:     jump = (op_a >= op_b);                     // BGEU
            default: jump = 1'b1;                               // JAL, JALR
        endcase
    end

endmodule

// File: load_store_unit.sv
// Load/store unit
// Wishbone classic master with byte lanes, store placement, load extension
`timescale 1ns/1ns

module load_store_unit
    import rv_exec_pkg::*;
    import exec_bus_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  instruction_type op,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    input  logic [XLEN-1:0] data,
    input  wb_rsp_t         wb_s,
    output wb_req_t         wb_m,
    output logic            done,
    output logic [XLEN-1:0] load_value,
    output logic            reg_we
);

    typedef enum logic {IDLE, BUSY} lsu_state_e;

    lsu_state_e        state;
    access_size_e      size;
    logic [XLEN-1:0]   adr;
    logic [XLEN-1:0]   dat_place;           // Store data on its lanes
    logic [XLEN/8-1:0] sel_place;
    logic              is_store;
    // Request held for the whole cycle
    instruction_type   op_q;
    logic [XLEN-1:0]   adr_q;
    logic [XLEN-1:0]   dat_w_q;
    logic [XLEN/8-1:0] sel_q;
    logic              we_q;
    logic [XLEN-1:0]   lane;                // Addressed lane at bit 0

    function automatic access_size_e size_of(input instruction_type o);
        case (o)
            OP0, OP1, OP7: return SZ_BYTE;  // LB, LBU, SB
            OP2, OP3, OP6: return SZ_HALF;  // LH, LHU, SH
            default:       return SZ_WORD;  // LW, SW
        endcase
    endfunction

    ////////////////////////////////////////
    // Request forming
    ////////////////////////////////////////
    assign adr      = op_a + op_b;
    assign size     = size_of(op);
    assign is_store = op inside {OP5, OP6, OP7};

    always_comb begin
        case (size)
            SZ_BYTE: begin
                dat_place = {4{data[7:0]}};             // Replicate on all lanes
                sel_place = 4'b0001 << adr[1:0];
            end
            SZ_HALF: begin
                dat_place = {2{data[15:0]}};
                sel_place = 4'b0011 << {adr[1], 1'b0};
            end
            default: begin
                dat_place = data;
                sel_place = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin                    // Payload, no reset
            op_q    <= op;
            adr_q   <= adr;
            dat_w_q <= dat_place;
            sel_q   <= sel_place;
            we_q    <= is_store;
        end
    end

    // Bus cycle FSM
    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= IDLE;
        else if (state == IDLE && start)
            state <= BUSY;                  // cyc rises next cycle
        else if (state == BUSY && wb_s.ack)
            state <= IDLE;                  // Drop on ack
    end

    assign wb_m = '{cyc: state == BUSY, stb: state == BUSY, we: we_q,
                    adr: adr_q, dat_w: dat_w_q, sel: sel_q};
    assign done   = (state == BUSY) && wb_s.ack;
    assign reg_we = !we_q;                  // Stores write nothing back

    ////////////////////////////////////////
    // Load extension
    ////////////////////////////////////////
    assign lane = wb_s.dat_r >> {adr_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            OP0:     load_value = {{(XLEN-8){lane[7]}}, lane[7:0]};     // LB
            OP1:     load_value = {{(XLEN-8){1'b0}}, lane[7:0]};        // LBU
            OP2:     load_value = {{(XLEN-16){lane[15]}}, lane[15:0]};  // LH
            OP3:     load_value = {{(XLEN-16){1'b0}}, lane[15:0]};      // LHU
            OP4:     load_value = wb_s.dat_r;                           // LW
            default: load_value = dat_w_q;  // Stores echo placed data
        endcase
    end

endmodule

// File: exec_dispatch.sv
// Execute dispatcher
// Pops the queue head, runs it on a unit, holds the result register
`timescale 1ns/1ns

module exec_dispatch
    import rv_exec_pkg::*;
    import exec_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  issue_pkt_t  head_pkt,
    input  logic        head_valid,
    output logic        pop,
    output result_pkt_t result,
    output logic        result_valid,
    input  logic        result_ready,
    output wb_req_t     wb_m,
    input  wb_rsp_t     wb_s
);

    logic [XLEN-1:0] int_value;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] br_link;
    logic            br_jump;
    logic            br_we;
    logic            is_mem;
    logic            is_branch;
    logic            mem_start;
    logic            mem_busy;              // One access in flight
    logic            lsu_done;
    logic [XLEN-1:0] lsu_value;
    logic            lsu_we;
    result_pkt_t     exec_res;              // Result of the head packet
    result_pkt_t     mem_res;               // Tag and link of the access

    int_unit u_int (
        .unit  (head_pkt.unit),
        .op    (head_pkt.op),
        .op_a  (head_pkt.op_a),
        .op_b  (head_pkt.op_b),
        .value (int_value)
    );

    branch_unit u_branch (
        .op     (head_pkt.op),
        .op_a   (head_pkt.op_a),
        .op_b   (head_pkt.op_b),
        .npc    (head_pkt.npc),
        .offset (head_pkt.offset),
        .target (br_target),
        .link   (br_link),
        .jump   (br_jump),
        .reg_we (br_we)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (mem_start),
        .op         (head_pkt.op),
        .op_a       (head_pkt.op_a),
        .op_b       (head_pkt.op_b),
        .data       (head_pkt.data),
        .wb_s       (wb_s),
        .wb_m       (wb_m),
        .done       (lsu_done),
        .load_value (lsu_value),
        .reg_we     (lsu_we)
    );

    ////////////////////////////////////////
    // Issue control
    ////////////////////////////////////////
    assign is_mem    = (head_pkt.unit == MEM_U);
    assign is_branch = (head_pkt.unit == BRANCH_U);
    assign pop       = head_valid && !mem_busy && (!result_valid || result_ready);
    assign mem_start = pop && is_mem;

    assign exec_res = '{tag: head_pkt.tag,
                        value: is_branch ? br_target : int_value,
                        link: br_link,
                        jump: is_branch && br_jump,
                        reg_we: is_branch ? br_we : 1'b1,
                        mem_fault: 1'b0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            mem_busy     <= 1'b0;
        end else begin
            if ((pop && !is_mem) || lsu_done)
                result_valid <= 1'b1;
            else if (result_ready)
                result_valid <= 1'b0;       // Taken by the consumer
            if (mem_start)
                mem_busy <= 1'b1;
            else if (lsu_done)
                mem_busy <= 1'b0;
        end
    end

    // Result payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (mem_start)
            mem_res <= exec_res;
        if (pop && !is_mem) begin
            result <= exec_res;
        end else if (lsu_done) begin
            result        <= mem_res;
            result.value  <= lsu_value;     // Load data on the ack edge
            result.jump   <= 1'b0;
            result.reg_we <= lsu_we;
        end
    end

endmodule

// File: execute_stage.sv
// Execute stage top
// Issue queue feeding the execute dispatcher
`timescale 1ns/1ns

module execute_stage
    import exec_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  issue_pkt_t  issue_pkt,
    input  logic        issue_valid,
    output logic        issue_ready,
    output result_pkt_t result,
    output logic        result_valid,
    input  logic        result_ready,
    output wb_req_t     wb_m,
    input  wb_rsp_t     wb_s
);

    issue_pkt_t head_pkt;                   // Oldest queued packet
    logic       head_valid;
    logic       pop;

    issue_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_pkt     (issue_pkt),
        .in_valid   (issue_valid),
        .in_ready   (issue_ready),
        .head_pkt   (head_pkt),
        .head_valid (head_valid),
        .pop        (pop)
    );

    exec_dispatch u_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_pkt     (head_pkt),
        .head_valid   (head_valid),
        .pop          (pop),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .wb_m         (wb_m),
        .wb_s         (wb_s)
    );

endmodule

// File: wb_data_mem.sv
// Wishbone classic data memory for the testbench
// Byte-lane writes, registered ack held back while stall is high
`timescale 1ns/1ns

module wb_data_mem
    import exec_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,                  // Random wait states
    input  wb_req_t wb_m,
    output wb_rsp_t wb_s
);

    logic [31:0] mem [256];                 // 1 KiB of words
    logic [7:0]  idx;
    logic        hit;                       // Request served this edge
    logic        ack;
    logic [31:0] dat_r;

    assign idx  = wb_m.adr[9:2];
    assign hit  = wb_m.cyc && wb_m.stb && !ack && !stall;
    assign wb_s = '{ack: ack, dat_r: dat_r};

    always_ff @(posedge clk) begin
        if (!rst_n)
            ack <= 1'b0;
        else
            ack <= hit;                     // One cycle, master drops cyc
    end

    // Storage and read port
    always @(posedge clk) begin
        if (hit && wb_m.we) begin
            for (int b = 0; b < 4; b++)
                if (wb_m.sel[b])
                    mem[idx][8*b +: 8] <= wb_m.dat_w[8*b +: 8];
        end
        if (hit)
            dat_r <= mem[idx];              // Old word, loads only
    end

endmodule

// File: execute_stage_tb.sv
// Execute stage testbench
// Table of issue packets and hand-worked results, random back-pressure and ack delay
`timescale 1ns/1ns

module execute_stage_tb
    import rv_exec_pkg::*;
    import exec_bus_pkg::*;
();

    localparam int WAIT_LIMIT = 200;        // Cycles per wait

    logic        clk;
    logic        rst_n;
    issue_pkt_t  issue_pkt;
    logic        issue_valid;
    logic        issue_ready;
    result_pkt_t result;
    logic        result_valid;
    logic        result_ready;
    wb_req_t     wb_m;
    wb_rsp_t     wb_s;
    logic        mem_stall;

    issue_pkt_t  pkt_q [$];                 // Stimulus rows
    result_pkt_t exp_q [$];                 // Expected result per row
    logic [31:0] rng;
    logic        hold;                      // Keeps result_ready low
    logic        timed_out;
    int          errors;
    int          checked;

    execute_stage UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_pkt    (issue_pkt),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .wb_m         (wb_m),
        .wb_s         (wb_s)
    );

    wb_data_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (mem_stall),
        .wb_m  (wb_m),
        .wb_s  (wb_s)
    );

    always #4 clk = ~clk;                   // 8 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // npc follows the row index, link is npc+4
    task automatic add_entry(input exec_unit_e unit, input instruction_type op,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] data, input logic [31:0] offset,
                             input logic [31:0] value, input logic jump, input logic we);
        issue_pkt_t  p;
        result_pkt_t r;
        p = '{unit: unit, op: op, op_a: a, op_b: b, data: data,
              npc: 32'h1000 + 32'(4 * pkt_q.size()), offset: offset,
              tag: TAG_W'(pkt_q.size())};
        r = '{tag: p.tag, value: value, link: p.npc + 32'd4, jump: jump,
              reg_we: we, mem_fault: 1'b0};
        pkt_q.push_back(p);
        exp_q.push_back(r);
    endtask

    task automatic build_table();
        ////////////////////////////////////////
        // Integer unit
        ////////////////////////////////////////
        add_entry(ADD_U, OP0, 32'h5, 32'hfffffff9, 32'h0, 32'h0, 32'hfffffffe, 1'b0, 1'b1);
        add_entry(ADD_U, OP1, 32'h3, 32'ha, 32'h0, 32'h0, 32'hfffffff9, 1'b0, 1'b1);
        add_entry(ADD_U, OP3, 32'hffffffff, 32'h1, 32'h0, 32'h0, 32'h1, 1'b0, 1'b1); // SLT
        add_entry(ADD_U, OP2, 32'hffffffff, 32'h1, 32'h0, 32'h0, 32'h0, 1'b0, 1'b1); // SLTU
        add_entry(LOGIC_U, OP0, 32'hf0f0f0f0, 32'hff00ff00, 32'h0, 32'h0, 32'h0ff00ff0, 1'b0, 1'b1);
        add_entry(LOGIC_U, OP1, 32'h12340000, 32'h5678, 32'h0, 32'h0, 32'h12345678, 1'b0, 1'b1);
        add_entry(LOGIC_U, OP2, 32'hf0f0f0f0, 32'hff00ff00, 32'h0, 32'h0, 32'hf000f000, 1'b0, 1'b1);
        add_entry(SHIFT_U, OP0, 32'h1, 32'h24, 32'h0, 32'h0, 32'h10, 1'b0, 1'b1);  // 36 masked
        add_entry(SHIFT_U, OP1, 32'h80000000, 32'h3f, 32'h0, 32'h0, 32'h1, 1'b0, 1'b1);
        add_entry(SHIFT_U, OP2, 32'h80000000, 32'h21, 32'h0, 32'h0, 32'hc0000000, 1'b0, 1'b1);
        add_entry(BYPASS_U, OP0, 32'hdeadb000, 32'h0, 32'h0, 32'h0, 32'hdeadb000, 1'b0, 1'b1);
        ////////////////////////////////////////
        // Branch unit, taken then not taken
        ////////////////////////////////////////
        add_entry(BRANCH_U, OP0, 32'h7, 32'h7, 32'h0, 32'h40, 32'h106c, 1'b1, 1'b0);
        add_entry(BRANCH_U, OP0, 32'h7, 32'h8, 32'h0, 32'hfffffff8, 32'h1028, 1'b0, 1'b0);
        add_entry(BRANCH_U, OP1, 32'h7, 32'h8, 32'h0, 32'h40, 32'h1074, 1'b1, 1'b0);
        add_entry(BRANCH_U, OP1, 32'h7, 32'h7, 32'h0, 32'h40, 32'h1078, 1'b0, 1'b0);
        add_entry(BRANCH_U, OP2, 32'hfffffffe, 32'h1, 32'h0, 32'h40, 32'h107c, 1'b1, 1'b0);
        add_entry(BRANCH_U, OP2, 32'h1, 32'hfffffffe, 32'h0, 32'h40, 32'h1080, 1'b0, 1'b0);
        add_entry(BRANCH_U, OP3, 32'h1, 32'hfffffffe, 32'h0, 32'h40, 32'h1084, 1'b1, 1'b0);
        add_entry(BRANCH_U, OP3, 32'hfffffffe, 32'h1, 32'h0, 32'h40, 32'h1088, 1'b0, 1'b0);
        add_entry(BRANCH_U, OP4, 32'h1, 32'hfffffffe, 32'h0, 32'h40, 32'h108c, 1'b1, 1'b0);
        add_entry(BRANCH_U, OP4, 32'hfffffffe, 32'h1, 32'h0, 32'h40, 32'h1090, 1'b0, 1'b0);
        add_entry(BRANCH_U, OP5, 32'hfffffffe, 32'h1, 32'h0, 32'h40, 32'h1094, 1'b1, 1'b0);
        add_entry(BRANCH_U, OP5, 32'h1, 32'hfffffffe, 32'h0, 32'h40, 32'h1098, 1'b0, 1'b0);
        add_entry(BRANCH_U, OP6, 32'h2000, 32'h124, 32'h0, 32'h0, 32'h2124, 1'b1, 1'b1); // JAL
        add_entry(BRANCH_U, OP7, 32'h3001, 32'h10, 32'h0, 32'h0, 32'h3010, 1'b1, 1'b1);  // JALR
        ////////////////////////////////////////
        // Stores, then loads of the same bytes
        ////////////////////////////////////////
        add_entry(MEM_U, OP5, 32'h100, 32'h0, 32'h8899aabb, 32'h0, 32'h8899aabb, 1'b0, 1'b0);
        add_entry(MEM_U, OP6, 32'h100, 32'h6, 32'hc3d4, 32'h0, 32'hc3d4c3d4, 1'b0, 1'b0);
        add_entry(MEM_U, OP7, 32'h100, 32'h5, 32'he7, 32'h0, 32'he7e7e7e7, 1'b0, 1'b0);
        add_entry(MEM_U, OP7, 32'h104, 32'h0, 32'h12, 32'h0, 32'h12121212, 1'b0, 1'b0);
        add_entry(MEM_U, OP4, 32'h100, 32'h0, 32'h0, 32'h0, 32'h8899aabb, 1'b0, 1'b1);  // LW
        add_entry(MEM_U, OP0, 32'h104, 32'h1, 32'h0, 32'h0, 32'hffffffe7, 1'b0, 1'b1);  // LB
        add_entry(MEM_U, OP1, 32'h100, 32'h5, 32'h0, 32'h0, 32'he7, 1'b0, 1'b1);        // LBU
        add_entry(MEM_U, OP2, 32'h100, 32'h6, 32'h0, 32'h0, 32'hffffc3d4, 1'b0, 1'b1);  // LH
        add_entry(MEM_U, OP3, 32'h106, 32'h0, 32'h0, 32'h0, 32'hc3d4, 1'b0, 1'b1);      // LHU
        add_entry(MEM_U, OP0, 32'h100, 32'h4, 32'h0, 32'h0, 32'h12, 1'b0, 1'b1);        // Positive LB
        add_entry(MEM_U, OP1, 32'h100, 32'h3, 32'h0, 32'h0, 32'h88, 1'b0, 1'b1);
        add_entry(MEM_U, OP2, 32'h100, 32'h2, 32'h0, 32'h0, 32'hffff8899, 1'b0, 1'b1);
    endtask

    task automatic drive_all();
        int wait_cnt;
        for (int i = 0; i < pkt_q.size() && !timed_out; i++) begin
            issue_pkt   = pkt_q[i];
            issue_valid = 1'b1;
            wait_cnt    = 0;
            while (!issue_ready && wait_cnt < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                wait_cnt++;
            end
            if (!issue_ready) begin
                $display("Timeout: issue_ready stayed low for entry %0d", i);
                errors++;
                timed_out = 1'b1;
            end else begin
                @(posedge clk);             // Transfer edge
                #1;
            end
            // First result held, so QUEUE_DEPTH packets now wait
            if (i == QUEUE_DEPTH && hold) begin
                if (issue_ready !== 1'b0) begin
                    $display("[FAIL] %0t: issue_ready high with a full queue", $time);
                    errors++;
                end
                hold <= 1'b0;
            end
        end
        issue_valid = 1'b0;
    endtask

    task automatic collect_all();
        int          wait_cnt;
        result_pkt_t want;
        for (int n = 0; n < exp_q.size() && !timed_out; n++) begin
            wait_cnt = 0;
            do begin
                @(posedge clk);
                #1;
                rng          = xorshift(rng);
                mem_stall    = rng[0];
                result_ready = !hold && rng[5];
                wait_cnt++;
            end while (!(result_valid && result_ready) && wait_cnt < WAIT_LIMIT);
            if (!(result_valid && result_ready)) begin
                $display("Timeout: no result for entry %0d", n);
                errors++;
                timed_out = 1'b1;
            end else begin
                want = exp_q[n];
                checked++;
                if (result.tag !== want.tag)
                    $display("[FAIL] %0t: tag %0d, expected %0d", $time, result.tag, want.tag);
                if (result.value !== want.value)
                    $display("[FAIL] %0t: entry %0d value %h, expected %h", $time, n,
                             result.value, want.value);
                if (result.link !== want.link)
                    $display("[FAIL] %0t: entry %0d link %h, expected %h", $time, n,
                             result.link, want.link);
                if (result.jump !== want.jump || result.reg_we !== want.reg_we)
                    $display("[FAIL] %0t: entry %0d jump/reg_we %b%b, expected %b%b", $time, n,
                             result.jump, result.reg_we, want.jump, want.reg_we);
                if (result.mem_fault !== 1'b0)
                    $display("[FAIL] %0t: entry %0d mem_fault set", $time, n);
                if (result.tag !== want.tag || result.value !== want.value ||
                    result.link !== want.link || result.jump !== want.jump ||
                    result.reg_we !== want.reg_we || result.mem_fault !== 1'b0)
                    errors++;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        issue_pkt    = '0;
        issue_valid  = 1'b0;
        result_ready = 1'b0;
        mem_stall    = 1'b0;
        hold         = 1'b1;
        timed_out    = 1'b0;
        errors       = 0;
        checked      = 0;
        rng          = 32'hcc5f;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (result_valid !== 1'b0 || wb_m.cyc !== 1'b0 || wb_m.stb !== 1'b0 ||
            issue_ready !== 1'b1) begin
            $display("[FAIL] %0t: outputs not idle after reset", $time);
            errors++;
        end
        fork
            drive_all();
            collect_all();
        join
        // Nothing may follow the last result
        repeat (8) begin
            @(posedge clk);
            #1;
            if (result_valid !== 1'b0 || issue_ready !== 1'b1) begin
                $display("[FAIL] %0t: extra result or queue not drained", $time);
                errors++;
            end
        end
        $display("Checked %0d of %0d results, %0d errors", checked, exp_q.size(), errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: execute_stage.f
rv_exec_pkg.sv
exec_bus_pkg.sv
issue_queue.sv
int_unit.sv
branch_unit.sv
load_store_unit.sv
exec_dispatch.sv
execute_stage.sv
wb_data_mem.sv
execute_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module execute_stage_tb \
    -f execute_stage.f -o execute_stage_sim > build.log 2>&1 \
    && ./obj_dir/execute_stage_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
